// File: src/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // screen coordinate, wide enough for the full 800 count line
    typedef logic [10:0] coord_t;

    // one colour channel as driven to the video dac
    typedef logic [9:0] chan_t;

    // horizontal timing in pixel clocks
    // 640x480 at 60 hz with a 25 mhz pixel clock
    localparam coord_t h_visible = 11'd640;
    localparam coord_t h_front   = 11'd16;
    localparam coord_t h_sync    = 11'd96;
    localparam coord_t h_back    = 11'd48;
    localparam coord_t h_total   = h_visible + h_front + h_sync + h_back;

    // vertical timing in lines
    localparam coord_t v_visible = 11'd480;
    localparam coord_t v_front   = 11'd10;
    localparam coord_t v_sync    = 11'd2;
    localparam coord_t v_back    = 11'd33;
    localparam coord_t v_total   = v_visible + v_front + v_sync + v_back;

    // sync windows, counted from the start of the visible area
    localparam coord_t h_sync_start = h_visible + h_front;
    localparam coord_t h_sync_end   = h_sync_start + h_sync;
    localparam coord_t v_sync_start = v_visible + v_front;
    localparam coord_t v_sync_end   = v_sync_start + v_sync;

endpackage

`default_nettype wire

// File: src/disp_pkg.sv
`default_nettype none

package disp_pkg;

    // one decimal or hex digit
    typedef logic [3:0] digit_t;

    // active low segments, bit 0 is a and bit 6 is g
    typedef logic [6:0] seg7_t;

    // history of identified digits
    localparam int hist_depth = 8;
    localparam int hist_idx_w = $clog2(hist_depth);

    // strip layout, eight cells cover the visible width
    localparam vga_pkg::coord_t cell_width  = 11'd80;
    localparam vga_pkg::coord_t band_top    = 11'd200;
    localparam vga_pkg::coord_t band_height = 11'd64;

    // palette
    localparam vga_pkg::chan_t chan_grey    = 10'd512;
    localparam vga_pkg::chan_t chan_bg_blue = 10'd256;
    localparam vga_pkg::chan_t chan_white   = 10'd1023;

    // hex glyphs, lower case b and d so they differ from 8 and 0
    function automatic seg7_t seg7_decode(input digit_t d);
        seg7_t seg;
        case (d)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'ha: seg = 7'h08;
            4'hb: seg = 7'h03;
            4'hc: seg = 7'h46;
            4'hd: seg = 7'h21;
            4'he: seg = 7'h06;
            default: seg = 7'h0e;
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// File: src/vga_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vga_if;

    // current pixel position, valid every cycle
    vga_pkg::coord_t x;
    vga_pkg::coord_t y;
    // inside the 640x480 window
    logic            active;
    // single cycle at h = 0, v = 0
    logic            frame_start;

    // timing generator side
    modport timing (
        output x, y, active, frame_start
    );

    // pixel renderer side
    modport render (
        input x, y, active, frame_start
    );

endinterface

`default_nettype wire

// File: src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic  i_clk,
    input  logic  i_arst_n,
    vga_if.timing o_pos,
    output logic  o_hs,
    output logic  o_vs,
    output logic  o_blank_n
);

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;
    logic            h_last;
    logic            v_last;
    logic            hs_now;
    logic            vs_now;
    logic            active_now;

    // end of line and end of frame
    assign h_last = (h_cnt == vga_pkg::h_total - 11'd1);
    assign v_last = (v_cnt == vga_pkg::v_total - 11'd1);

    // horizontal count, 0..799
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 11'd1;
        end
    end

    // vertical count, steps once per line
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 11'd1;
            end
        end
    end

    // visible, front porch, sync, back porch
    // sync pulses active low
    assign hs_now = !((h_cnt >= vga_pkg::h_sync_start) && (h_cnt < vga_pkg::h_sync_end));
    assign vs_now = !((v_cnt >= vga_pkg::v_sync_start) && (v_cnt < vga_pkg::v_sync_end));
    assign active_now = (h_cnt < vga_pkg::h_visible) && (v_cnt < vga_pkg::v_visible);

    // position for the renderer, same cycle as the counters
    assign o_pos.x           = h_cnt;
    assign o_pos.y           = v_cnt;
    assign o_pos.active      = active_now;
    assign o_pos.frame_start = (h_cnt == '0) && (v_cnt == '0);

    // one stage delay
    // the renderer registers its colour, so sync and blank
    // must follow by the same single cycle to stay aligned
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hs      <= 1'b1;
            o_vs      <= 1'b1;
            o_blank_n <= 1'b1;
        end else begin
            o_hs      <= hs_now;
            o_vs      <= vs_now;
            o_blank_n <= active_now;
        end
    end

endmodule

`default_nettype wire

// File: src/digit_scroller.sv
`timescale 1ns/1ps
`default_nettype none

module digit_scroller (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    vga_if.render                 i_pos,
    input  logic                  i_identify,
    input  disp_pkg::digit_t      i_answer,
    output vga_pkg::chan_t        o_red,
    output vga_pkg::chan_t        o_green,
    output vga_pkg::chan_t        o_blue
);

    // history, slot 0 is the newest entry
    disp_pkg::digit_t                   hist_digit [disp_pkg::hist_depth];
    logic [disp_pkg::hist_depth-1:0]    hist_valid;

    // strip offset in pixels, 0..639
    vga_pkg::coord_t                    disp;

    vga_pkg::coord_t                    col_sum;
    vga_pkg::coord_t                    col;
    vga_pkg::coord_t                    slot_full;
    logic [disp_pkg::hist_idx_w-1:0]    slot_idx;
    logic                               in_band;
    logic                               on_border;
    disp_pkg::digit_t                   slot_digit;
    vga_pkg::chan_t                     slot_ramp;

    vga_pkg::chan_t                     next_red;
    vga_pkg::chan_t                     next_green;
    vga_pkg::chan_t                     next_blue;

    // valid bits shift in step with the digits
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hist_valid <= '0;
        end else if (i_identify) begin
            hist_valid <= {hist_valid[disp_pkg::hist_depth-2:0], 1'b1};
        end
    end

    // digit storage
    // oldest entry falls off the top
    always_ff @(posedge i_clk) begin
        if (i_identify) begin
            hist_digit[0] <= i_answer;
            for (int i = 1; i < disp_pkg::hist_depth; i++) begin
                hist_digit[i] <= hist_digit[i-1];
            end
        end
    end

    // one pixel per frame, wraps at the visible width
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            disp <= '0;
        end else if (i_pos.frame_start) begin
            if (disp == vga_pkg::h_visible - 11'd1) begin
                disp <= '0;
            end else begin
                disp <= disp + 11'd1;
            end
        end
    end

    // shifted column, both terms below 640 so one subtract is enough
    assign col_sum = i_pos.x + disp;
    assign col     = (col_sum >= vga_pkg::h_visible) ? col_sum - vga_pkg::h_visible : col_sum;

    // cell lookup
    assign slot_full  = col / disp_pkg::cell_width;
    assign slot_idx   = slot_full[disp_pkg::hist_idx_w-1:0];
    assign on_border  = ((col % disp_pkg::cell_width) == '0);
    assign slot_digit = hist_digit[slot_idx];
    // d * 64
    assign slot_ramp  = {slot_digit, 6'd0};

    // rows of the strip
    assign in_band = (i_pos.y >= disp_pkg::band_top) &&
                     (i_pos.y < disp_pkg::band_top + disp_pkg::band_height);

    always_comb begin
        // blanked area stays black
        next_red   = '0;
        next_green = '0;
        next_blue  = '0;
        if (i_pos.active) begin
            if (!in_band) begin
                next_blue = disp_pkg::chan_bg_blue;
            end else if (on_border) begin
                next_red   = disp_pkg::chan_white;
                next_green = disp_pkg::chan_white;
                next_blue  = disp_pkg::chan_white;
            end else if (!hist_valid[slot_idx]) begin
                next_red   = disp_pkg::chan_grey;
                next_green = disp_pkg::chan_grey;
                next_blue  = disp_pkg::chan_grey;
            end else begin
                // red rises and green falls with the digit value
                next_red   = slot_ramp;
                next_green = disp_pkg::chan_white - slot_ramp;
                next_blue  = disp_pkg::chan_grey;
            end
        end
    end

    // colour register, one cycle after the position
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
        end else begin
            o_red   <= next_red;
            o_green <= next_green;
            o_blue  <= next_blue;
        end
    end

endmodule

`default_nettype wire

// File: src/status_panel.sv
`timescale 1ns/1ps
`default_nettype none

module status_panel (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic [9:0]          i_sw,
    input  logic                i_key_identify_n,
    output logic                o_identify,
    output disp_pkg::digit_t    o_answer,
    output disp_pkg::seg7_t     o_hex_answer,
    output disp_pkg::seg7_t     o_hex_count
);

    disp_pkg::digit_t answer;
    disp_pkg::digit_t id_count;
    logic             key_meta;
    logic             key_sync;
    logic             key_prev;

    // highest closed switch among 9..1 wins
    // switch 0 alone reads as digit 0
    always_comb begin
        answer = '0;
        for (int i = 1; i < 10; i++) begin
            if (i_sw[i]) begin
                answer = disp_pkg::digit_t'(i);
            end
        end
    end

    assign o_answer = answer;

    // key is asynchronous to the pixel clock
    // released level after reset, so no false press
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
            key_prev <= 1'b1;
        end else begin
            key_meta <= i_key_identify_n;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    // press is a high to low step of the synchronised key
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_identify <= 1'b0;
        end else begin
            o_identify <= key_prev && !key_sync;
        end
    end

    // identification count, wraps at 16
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_count <= '0;
        end else if (o_identify) begin
            id_count <= id_count + 4'd1;
        end
    end

    // registered segment drivers
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hex_answer <= disp_pkg::seg7_decode(4'd0);
            o_hex_count  <= disp_pkg::seg7_decode(4'd0);
        end else begin
            o_hex_answer <= disp_pkg::seg7_decode(answer);
            o_hex_count  <= disp_pkg::seg7_decode(id_count);
        end
    end

endmodule

`default_nettype wire

// File: src/digit_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module digit_display_top (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic [9:0]          i_sw,
    input  logic                i_key_identify_n,
    output vga_pkg::chan_t      o_vga_r,
    output vga_pkg::chan_t      o_vga_g,
    output vga_pkg::chan_t      o_vga_b,
    output logic                o_vga_hs,
    output logic                o_vga_vs,
    output logic                o_vga_blank_n,
    output disp_pkg::seg7_t     o_hex_answer,
    output disp_pkg::seg7_t     o_hex_count
);

    // panel to scroller
    logic             identify;
    disp_pkg::digit_t answer;

    // pixel position bus
    vga_if u_pos ();

    // 640x480 timing
    vga_timing u_timing (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .o_pos     (u_pos),
        .o_hs      (o_vga_hs),
        .o_vs      (o_vga_vs),
        .o_blank_n (o_vga_blank_n)
    );

    // strip of recent digits
    digit_scroller u_scroller (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_pos      (u_pos),
        .i_identify (identify),
        .i_answer   (answer),
        .o_red      (o_vga_r),
        .o_green    (o_vga_g),
        .o_blue     (o_vga_b)
    );

    // switches, key and seven segment digits
    status_panel u_panel (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_sw             (i_sw),
        .i_key_identify_n (i_key_identify_n),
        .o_identify       (identify),
        .o_answer         (answer),
        .o_hex_answer     (o_hex_answer),
        .o_hex_count      (o_hex_count)
    );

endmodule

`default_nettype wire

// File: verif/tb_digit_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_digit_display;

    // four frames of 800 x 525 cycles plus margin
    localparam int timeout_cycles = 2_000_000;

    logic       i_clk;
    logic       i_arst_n;
    logic [9:0] i_sw;
    logic       i_key_identify_n;
    logic [9:0] o_vga_r;
    logic [9:0] o_vga_g;
    logic [9:0] o_vga_b;
    logic       o_vga_hs;
    logic       o_vga_vs;
    logic       o_vga_blank_n;
    logic [6:0] o_hex_answer;
    logic [6:0] o_hex_count;

    // active low glyphs, bit 0 is segment a
    logic [6:0] glyph_rom [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                   7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    // reference model state
    int    ref_h;
    int    ref_v;
    int    ref_disp;
    int    ref_hist [$];
    int    n_presses;
    logic  h_locked;
    logic  v_locked;
    logic  sync_from_reset;
    logic  prev_hs;
    logic  prev_vs;
    logic  arst_at_pos;
    int    hs_rises;
    int    pix_checks;
    event  hs_rise_ev;
    event  hs_fall_ev;
    event  vs_fall_ev;
    event  vs_rise_ev;

    // bookkeeping
    int    cycle_cnt;
    int    n_checks;
    int    n_errors;
    int    err_at_start;
    int    test_num;
    int    tests_passed;
    int    tests_failed;
    string test_name;

    digit_display_top u_dut (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_sw             (i_sw),
        .i_key_identify_n (i_key_identify_n),
        .o_vga_r          (o_vga_r),
        .o_vga_g          (o_vga_g),
        .o_vga_b          (o_vga_b),
        .o_vga_hs         (o_vga_hs),
        .o_vga_vs         (o_vga_vs),
        .o_vga_blank_n    (o_vga_blank_n),
        .o_hex_answer     (o_hex_answer),
        .o_hex_count      (o_hex_count)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    function automatic logic [6:0] glyph(input int d);
        return glyph_rom[d % 16];
    endfunction

    // highest closed switch among 9..1, else 0
    function automatic int highest_switch(input logic [9:0] sw);
        int d;
        d = 0;
        for (int i = 9; i >= 1; i--) begin
            if (sw[i] && d == 0) begin
                d = i;
            end
        end
        return d;
    endfunction

    // expected {hs, vs, blank_n} for a pin coordinate
    function automatic logic [2:0] ref_sync(input int h, input int v);
        return {!(h >= 656 && h < 752), !(v >= 490 && v < 492), (h < 640 && v < 480)};
    endfunction

    // expected {r, g, b} for a pin coordinate
    function automatic logic [29:0] ref_colour(input int h, input int v, input int disp);
        int col;
        int d;
        if (h >= 640 || v >= 480) begin
            return 30'd0;
        end
        if (v < 200 || v >= 264) begin
            return {10'd0, 10'd0, 10'd256};
        end
        col = (h + disp) % 640;
        if (col % 80 == 0) begin
            return {3{10'd1023}};
        end
        if (col / 80 >= ref_hist.size()) begin
            return {3{10'd512}};
        end
        d = ref_hist[col / 80];
        return {10'(d * 64), 10'(1023 - d * 64), 10'd512};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic test_start(input string name);
        test_num++;
        test_name    = name;
        err_at_start = n_errors;
    endtask

    task automatic test_end();
        if (n_errors == err_at_start) begin
            tests_passed++;
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, test_name, n_errors - err_at_start);
        end
    endtask

    // key held low for a number of cycles, then released
    task automatic press_key(input int low_cycles);
        @(negedge i_clk);
        i_key_identify_n <= 1'b0;
        repeat (low_cycles) @(negedge i_clk);
        i_key_identify_n <= 1'b1;
        repeat (10) @(negedge i_clk);
    endtask

    always @(posedge i_clk) begin
        arst_at_pos <= i_arst_n;
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // pin sampling on the falling edge, pins settle after the rising edge
    always @(negedge i_clk) begin : track
        logic [2:0] exp_sync;
        if (!(arst_at_pos && i_arst_n)) begin
            if (!i_arst_n) begin
                check_value("sync in reset", {o_vga_hs, o_vga_vs, o_vga_blank_n}, 3'b111);
                check_value("colour in reset", {o_vga_r, o_vga_g, o_vga_b}, 30'd0);
            end
            prev_hs = 1'b1;
            prev_vs = 1'b1;
            if (sync_from_reset) begin
                // next valid sample is pixel 0, 0
                ref_h    = 799;
                ref_v    = 524;
                h_locked = 1'b1;
                v_locked = 1'b1;
            end
        end else begin
            if (h_locked) begin
                ref_h = (ref_h == 799) ? 0 : ref_h + 1;
                if (v_locked && ref_h == 0) begin
                    ref_v = (ref_v == 524) ? 0 : ref_v + 1;
                end
            end
            // hs rises at count 752
            if (!prev_hs && o_vga_hs) begin
                hs_rises++;
                if (!h_locked) begin
                    ref_h    = 752;
                    h_locked = 1'b1;
                end
                -> hs_rise_ev;
            end
            if (prev_hs && !o_vga_hs) begin
                -> hs_fall_ev;
            end
            // vs falls at line 490, the strip steps once per frame
            if (prev_vs && !o_vga_vs) begin
                ref_disp = (ref_disp + 1) % 640;
                if (!v_locked) begin
                    ref_v    = 490;
                    v_locked = 1'b1;
                end
                -> vs_fall_ev;
            end
            if (!prev_vs && o_vga_vs) begin
                -> vs_rise_ev;
            end
            prev_hs = o_vga_hs;
            prev_vs = o_vga_vs;
            exp_sync = ref_sync(ref_h, ref_v);
            if (h_locked) begin
                check_value("hsync", o_vga_hs, exp_sync[2]);
            end
            if (h_locked && v_locked) begin
                pix_checks++;
                check_value("vsync", o_vga_vs, exp_sync[1]);
                check_value("blank_n", o_vga_blank_n, exp_sync[0]);
                check_value("colour", {o_vga_r, o_vga_g, o_vga_b},
                            ref_colour(ref_h, ref_v, ref_disp));
            end
        end
    end

    initial begin : main
        logic [9:0] sw;
        int         t0;
        int         t1;
        int         mark;
        void'($urandom(2));
        i_arst_n         = 1'b0;
        i_sw             = '0;
        i_key_identify_n = 1'b1;
        ref_disp         = 1;
        sync_from_reset  = 1'b0;
        // position unknown until the first sync edges
        h_locked         = 1'b0;
        v_locked         = 1'b0;

        test_start("reset values and line timing");
        repeat (4) @(negedge i_clk);
        i_arst_n <= 1'b1;
        #1;
        check_value("sync after reset", {o_vga_hs, o_vga_vs, o_vga_blank_n}, 3'b111);
        check_value("colour after reset", {o_vga_r, o_vga_g, o_vga_b}, 30'd0);
        @(hs_rise_ev);
        t0 = cycle_cnt;
        @(hs_fall_ev);
        t1 = cycle_cnt;
        @(hs_rise_ev);
        check_value("line length", cycle_cnt - t0, 800);
        check_value("hsync width", cycle_cnt - t1, 96);
        test_end();

        test_start("answer switches");
        for (int n = 0; n < 40; n++) begin
            sw = 10'($urandom % 1024);
            @(negedge i_clk);
            i_sw <= sw;
            repeat (2) @(negedge i_clk);
            check_value("hex answer", o_hex_answer, glyph(highest_switch(sw)));
        end
        test_end();

        // wraps the count past 16 and overfills the history
        test_start("identify count");
        for (int n = 0; n < 18; n++) begin
            sw = 10'($urandom % 1024);
            @(negedge i_clk);
            i_sw <= sw;
            repeat (2) @(negedge i_clk);
            press_key(1 + $urandom % 16);
            ref_hist.push_front(highest_switch(sw));
            if (ref_hist.size() > 8) begin
                void'(ref_hist.pop_back());
            end
            n_presses++;
            check_value("hex count", o_hex_count, glyph(n_presses % 16));
        end
        test_end();

        // first full frame starts right after the first vs fall
        test_start("frame timing and first frame");
        @(vs_fall_ev);
        t0   = hs_rises;
        mark = pix_checks;
        @(vs_rise_ev);
        check_value("vsync lines", hs_rises - t0, 2);
        @(vs_fall_ev);
        check_value("frame lines", hs_rises - t0, 525);
        check_value("pixels compared", pix_checks - mark, 420000);
        test_end();

        test_start("scrolled frame");
        mark = pix_checks;
        @(vs_fall_ev);
        check_value("pixels compared", pix_checks - mark, 420000);
        test_end();

        // reset near line 100 of the next frame
        test_start("mid-frame reset");
        repeat (135 * 800 + 321) @(negedge i_clk);
        sync_from_reset = 1'b1;
        i_arst_n <= 1'b0;
        @(posedge i_clk);
        ref_hist.delete();
        n_presses = 0;
        ref_disp  = 1;
        repeat (4) @(negedge i_clk);
        i_arst_n <= 1'b1;
        repeat (2) @(negedge i_clk);
        check_value("hex count after reset", o_hex_count, glyph(0));
        // band ends at line 264
        repeat (270 * 800) @(negedge i_clk);
        test_end();

        $display("summary: %0d checks, %0d errors, %0d tests ok, %0d tests failed",
                 n_checks, n_errors, tests_passed, tests_failed);
        if (n_errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/vga_pkg.sv
src/disp_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/digit_scroller.sv
src/status_panel.sv
src/digit_display_top.sv
verif/tb_digit_display.sv

// File: Bender.yml
package:
  name: digit_display

sources:
  # packages first, the scroller and panel use both
  - src/vga_pkg.sv
  - src/disp_pkg.sv
  - src/vga_if.sv
  - src/vga_timing.sv
  - src/digit_scroller.sv
  - src/status_panel.sv
  - src/digit_display_top.sv

  # simulation only
  - target: test
    files:
      - verif/tb_digit_display.sv
